/* files.f */
logic/grn_pkg.sv
logic/grn_job_pkg.sv
logic/net_sim.sv
logic/step_counter.sv
logic/attractor_fsm.sv
logic/job_fifo.sv
logic/attractor_top.sv
test/tb_clock.sv
test/tb_attractor.sv

/* Makefile */
TOP := tb_attractor

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f files.f -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

/* test/tb_attractor.sv */
module tb_attractor;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int drain_limit = 200000;
  localparam int wait_limit = 2000;

  logic                 clk;
  logic                 rst;
  logic                 job_we;
  grn_job_pkg::job_t    job;
  logic                 job_full;
  logic                 jobs_end;
  logic                 res_re;
  grn_job_pkg::result_t result;
  logic                 res_empty;
  logic                 done;

  grn_job_pkg::result_t expected_q[$];
  int                   stall_len[64];
  int                   error_count = 0;
  int                   timeout_count = 0;
  int                   checked_count = 0;
  int                   hold_cycles = 0;
  logic                 stall_mode = 1'b0;

  tb_clock clock_i (.clk(clk), .rst(rst));

  attractor_top attractor_top_i (
    .clk       (clk),
    .rst       (rst),
    .job_we    (job_we),
    .job       (job),
    .job_full  (job_full),
    .jobs_end  (jobs_end),
    .res_re    (res_re),
    .result    (result),
    .res_empty (res_empty),
    .done      (done)
  );

  function automatic grn_pkg::net_state_t rotate_right(input grn_pkg::net_state_t s,
                                                       input int n);
    logic [2*grn_pkg::n_genes-1:0] dbl;
    dbl = {s, s};
    return dbl[n +: grn_pkg::n_genes];
  endfunction

  // gene i sees gene i+1, i+3 and i+7, so the rule is a sum of rotations.
  function automatic grn_pkg::net_state_t apply_rule(input grn_pkg::net_state_t s);
    return rotate_right(s, 1) ^ (rotate_right(s, 3) & ~rotate_right(s, 7));
  endfunction

  function automatic grn_job_pkg::result_t ref_result(input grn_pkg::net_state_t init);
    grn_job_pkg::result_t r;
    grn_pkg::net_state_t  slow;
    grn_pkg::net_state_t  fast;
    grn_pkg::net_state_t  walk;
    int                   k;
    int                   p;
    slow = apply_rule(init);
    fast = apply_rule(apply_rule(init));
    k = 1;
    while (slow != fast) begin
      slow = apply_rule(slow);
      fast = apply_rule(apply_rule(fast));
      k++;
    end
    walk = apply_rule(slow);
    p = 1;
    while (walk != slow) begin
      walk = apply_rule(walk);
      p++;
    end
    r.init_state      = init;
    r.attractor_state = slow;
    r.transient       = grn_pkg::step_count_t'(k);
    r.period          = grn_pkg::step_count_t'(p);
    return r;
  endfunction

  task automatic check_result(input grn_job_pkg::result_t got);
    grn_job_pkg::result_t exp;
    if (expected_q.size() == 0) begin
      $display("result for initial state %h arrived with no job outstanding", got.init_state);
      error_count++;
      return;
    end
    exp = expected_q.pop_front();
    checked_count++;
    assert (got.init_state == exp.init_state) else begin
      $display("[ERROR] %0t ns: init_state %h, expected %h", $time, got.init_state,
               exp.init_state);
      error_count++;
    end
    assert (got.attractor_state == exp.attractor_state) else begin
      $display("[ERROR] %0t ns: attractor_state %h for init %h, expected %h", $time,
               got.attractor_state, exp.init_state, exp.attractor_state);
      error_count++;
    end
    assert (got.transient == exp.transient) else begin
      $display("[ERROR] %0t ns: transient %0d for init %h, expected %0d", $time,
               got.transient, exp.init_state, exp.transient);
      error_count++;
    end
    assert (got.period == exp.period) else begin
      $display("[ERROR] %0t ns: period %0d for init %h, expected %0d", $time,
               got.period, exp.init_state, exp.period);
      error_count++;
    end
    assert (!done) else begin
      $display("[ERROR] %0t ns: done high while a result was still queued", $time);
      error_count++;
    end
  endtask

  task automatic write_job(input grn_pkg::net_state_t first, input grn_pkg::net_state_t last);
    int n;
    n = 0;
    while (job_full && n < wait_limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (job_full) begin
      $display("timeout: job FIFO stayed full, job %h..%h was never written", first, last);
      timeout_count++;
      return;
    end
    for (int s = int'(first); s <= int'(last); s++) begin
      expected_q.push_back(ref_result(grn_pkg::net_state_t'(s)));
    end
    job.first_state = first;
    job.last_state  = last;
    job_we          = 1'b1;
    @(posedge clk);
    #1;
    job_we = 1'b0;
  endtask

  task automatic wait_drained(input string what);
    int n;
    n = 0;
    while (expected_q.size() > 0 && n < drain_limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (expected_q.size() > 0) begin
      $display("timeout: %0d results of the %s never arrived", expected_q.size(), what);
      timeout_count++;
      expected_q.delete();
    end
  endtask

  // pops whenever allowed, pauses from the stall table in back-pressure mode.
  initial begin : result_reader
    int idx;
    idx = 0;
    res_re = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      res_re = 1'b0;
      if (rst) begin
        hold_cycles = 0;
      end else if (hold_cycles > 0) begin
        hold_cycles--;
      end else if (!res_empty) begin
        res_re = 1'b1;
        check_result(result);
        if (stall_mode) begin
          hold_cycles = stall_len[idx];
          idx = (idx + 1) % 64;
        end
      end
    end
  end

  initial begin : stimulus
    int n;
    int first;
    int len;
    void'($urandom(61));
    job_we   = 1'b0;
    job      = '0;
    jobs_end = 1'b0;
    for (int i = 0; i < 64; i++) begin
      stall_len[i] = $urandom_range(0, 40);
    end

    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (rst && n < 20);
    #1;
    if (rst) begin
      $display("timeout: reset never released");
      timeout_count++;
    end

    // idle engine after reset.
    assert (!done && res_empty) else begin
      $display("[ERROR] %0t ns: after reset done=%b res_empty=%b", $time, done, res_empty);
      error_count++;
    end
    for (int i = 0; i < 10; i++) begin
      assert (res_empty) else begin
        $display("[ERROR] %0t ns: result present before any job", $time);
        error_count++;
      end
      @(posedge clk);
      #1;
    end

    write_job(12'h0a5, 12'h0a5);
    wait_drained("single-state job");
    // no second result for the same job.
    for (int i = 0; i < 100; i++) begin
      assert (res_empty) else begin
        $display("[ERROR] %0t ns: extra result after a single-state job", $time);
        error_count++;
      end
      @(posedge clk);
      #1;
    end

    write_job(12'h300, 12'h313); // 20 consecutive states.
    wait_drained("range job");

    // back to back until the job FIFO pushes back.
    n = 0;
    while (!job_full && n < 50) begin
      first = $urandom_range(0, 4090);
      len = $urandom_range(0, 5);
      write_job(grn_pkg::net_state_t'(first), grn_pkg::net_state_t'(first + len));
      n++;
    end
    if (!job_full) begin
      $display("timeout: job FIFO never reported full after %0d jobs", n);
      timeout_count++;
    end
    wait_drained("back-to-back jobs");

    stall_mode  = 1'b1;
    hold_cycles = 300; // lets the result FIFO fill up.
    for (int j = 0; j < 4; j++) begin
      first = $urandom_range(0, 4080);
      len = $urandom_range(4, 8);
      write_job(grn_pkg::net_state_t'(first), grn_pkg::net_state_t'(first + len));
    end

    assert (!done) else begin
      $display("[ERROR] %0t ns: done high before jobs_end", $time);
      error_count++;
    end
    jobs_end = 1'b1; // done must stay low while results remain.
    wait_drained("back-pressure jobs");
    stall_mode = 1'b0;

    n = 0;
    while (!done && n < wait_limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!done) begin
      $display("timeout: done never rose after jobs_end and the last result");
      timeout_count++;
    end else begin
      for (int i = 0; i < 20; i++) begin
        assert (done && res_empty) else begin
          $display("[ERROR] %0t ns: after done, done=%b res_empty=%b", $time, done, res_empty);
          error_count++;
        end
        @(posedge clk);
        #1;
      end
    end

    $display("summary: %0d results checked, %0d errors, %0d timeouts", checked_count,
             error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* test/tb_clock.sv */
module tb_clock (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period.
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0; // released just after the third edge.
  end

endmodule

/* logic/attractor_top.sv */
module attractor_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 job_we,
  input  grn_job_pkg::job_t    job,
  output logic                 job_full,
  input  logic                 jobs_end,
  input  logic                 res_re,
  output grn_job_pkg::result_t result,
  output logic                 res_empty,
  output logic                 done
);

  grn_job_pkg::job_t    job_head;
  logic                 job_empty;
  logic                 job_re;
  logic                 sim_load;
  grn_pkg::net_state_t  sim_init;
  logic                 tort_en;
  logic                 hare_en;
  grn_pkg::net_state_t  tort_state;
  grn_pkg::net_state_t  hare_state;
  logic                 cnt_clear;
  logic                 cnt_en;
  grn_pkg::step_count_t cnt_value;
  logic                 res_full;
  logic                 res_we;
  grn_job_pkg::result_t res_data;

  job_fifo #(
    .WIDTH($bits(grn_job_pkg::job_t)),
    .DEPTH(grn_job_pkg::job_depth)
  ) jobs_i (
    .clk   (clk),
    .rst   (rst),
    .we    (job_we),
    .wdata (job),
    .full  (job_full),
    .re    (job_re),
    .rdata (job_head),
    .empty (job_empty)
  );

  job_fifo #(
    .WIDTH($bits(grn_job_pkg::result_t)),
    .DEPTH(grn_job_pkg::result_depth)
  ) results_i (
    .clk   (clk),
    .rst   (rst),
    .we    (res_we),
    .wdata (res_data),
    .full  (res_full),
    .re    (res_re),
    .rdata (result),
    .empty (res_empty)
  );

  net_sim #(.STEPS(1)) tortoise_i (
    .clk   (clk),
    .rst   (rst),
    .load  (sim_load),
    .init  (sim_init),
    .en    (tort_en),
    .state (tort_state)
  );

  net_sim #(.STEPS(2)) hare_i (
    .clk   (clk),
    .rst   (rst),
    .load  (sim_load),
    .init  (sim_init),
    .en    (hare_en),
    .state (hare_state)
  );

  step_counter step_counter_i (
    .clk   (clk),
    .rst   (rst),
    .clear (cnt_clear),
    .en    (cnt_en),
    .value (cnt_value)
  );

  attractor_fsm attractor_fsm_i (
    .clk        (clk),
    .rst        (rst),
    .jobs_end   (jobs_end),
    .job_empty  (job_empty),
    .job_head   (job_head),
    .job_re     (job_re),
    .sim_load   (sim_load),
    .sim_init   (sim_init),
    .tort_en    (tort_en),
    .hare_en    (hare_en),
    .tort_state (tort_state),
    .hare_state (hare_state),
    .cnt_clear  (cnt_clear),
    .cnt_en     (cnt_en),
    .cnt_value  (cnt_value),
    .res_full   (res_full),
    .res_empty  (res_empty),
    .res_we     (res_we),
    .res_data   (res_data),
    .done       (done)
  );

endmodule

/* logic/job_fifo.sv */
module job_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  logic [WIDTH-1:0] wdata,
  output logic             full,
  input  logic             re,
  output logic [WIDTH-1:0] rdata,
  output logic             empty
);

  localparam int aw = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cw = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [aw-1:0]    wr_ptr;
  logic [aw-1:0]    rd_ptr;
  logic [cw-1:0]    count;
  logic             do_wr;
  logic             do_rd;

  assign full  = (count == cw'(DEPTH));
  assign empty = (count == '0);
  assign do_wr = we && !full;
  assign do_rd = re && !empty;
  assign rdata = mem[rd_ptr]; // head shown without a read cycle.

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == aw'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == aw'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + cw'(do_wr) - cw'(do_rd);
    end
  end

  a_write_full: assert property (@(posedge clk) disable iff (rst) we |-> !full)
    else $error("job_fifo: write while full, entry dropped");

  a_read_empty: assert property (@(posedge clk) disable iff (rst) re |-> !empty)
    else $error("job_fifo: read while empty");

endmodule

/* logic/attractor_fsm.sv */
module attractor_fsm (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   jobs_end,
  input  logic                   job_empty,
  input  grn_job_pkg::job_t      job_head,
  output logic                   job_re,
  output logic                   sim_load,
  output grn_pkg::net_state_t    sim_init,
  output logic                   tort_en,
  output logic                   hare_en,
  input  grn_pkg::net_state_t    tort_state,
  input  grn_pkg::net_state_t    hare_state,
  output logic                   cnt_clear,
  output logic                   cnt_en,
  input  grn_pkg::step_count_t   cnt_value,
  input  logic                   res_full,
  input  logic                   res_empty,
  output logic                   res_we,
  output grn_job_pkg::result_t   res_data,
  output logic                   done
);

  grn_pkg::fsm_state_e  state;
  grn_pkg::fsm_state_e  state_next;
  grn_pkg::net_state_t  cur_state;
  grn_pkg::net_state_t  last_state;
  grn_pkg::net_state_t  attr_state;
  grn_pkg::step_count_t transient;
  grn_pkg::step_count_t period;
  logic                 meet;
  logic                 returned;

  assign meet     = (tort_state == hare_state) && (cnt_value != '0);
  assign returned = (tort_state == attr_state) && (cnt_value != '0);
  assign sim_init = cur_state;

  assign res_data.init_state      = cur_state;
  assign res_data.attractor_state = attr_state;
  assign res_data.transient       = transient;
  assign res_data.period          = period;

  always_comb begin
    state_next = state;
    job_re     = 1'b0;
    sim_load   = 1'b0;
    tort_en    = 1'b0;
    hare_en    = 1'b0;
    cnt_clear  = 1'b0;
    cnt_en     = 1'b0;
    res_we     = 1'b0;
    case (state)
      grn_pkg::st_idle, grn_pkg::st_done: begin
        if (!job_empty) begin
          state_next = grn_pkg::st_fetch;
        end else if (jobs_end) begin
          state_next = grn_pkg::st_done;
        end
      end
      grn_pkg::st_fetch: begin
        job_re     = 1'b1;
        state_next = grn_pkg::st_load;
      end
      grn_pkg::st_load: begin
        sim_load   = 1'b1;
        cnt_clear  = 1'b1;
        state_next = grn_pkg::st_seek;
      end
      grn_pkg::st_seek: begin
        if (meet) begin
          cnt_clear  = 1'b1; // restart count for the period.
          state_next = grn_pkg::st_measure;
        end else begin
          tort_en = 1'b1;
          hare_en = 1'b1;
          cnt_en  = 1'b1;
        end
      end
      grn_pkg::st_measure: begin
        if (returned) begin
          state_next = grn_pkg::st_emit;
        end else begin
          tort_en = 1'b1;
          cnt_en  = 1'b1;
        end
      end
      grn_pkg::st_emit: begin
        if (!res_full) begin
          res_we = 1'b1;
          if (cur_state < last_state) begin
            state_next = grn_pkg::st_load;
          end else if (!job_empty) begin
            state_next = grn_pkg::st_fetch;
          end else if (jobs_end) begin
            state_next = grn_pkg::st_done;
          end else begin
            state_next = grn_pkg::st_idle;
          end
        end
      end
      default: state_next = grn_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= grn_pkg::st_idle;
      done  <= 1'b0;
    end else begin
      state <= state_next;
      if (state == grn_pkg::st_done && jobs_end && job_empty && res_empty) begin
        done <= 1'b1; // sticky until reset.
      end
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      grn_pkg::st_fetch: begin
        cur_state  <= job_head.first_state;
        last_state <= job_head.last_state;
      end
      grn_pkg::st_seek: begin
        if (meet) begin
          attr_state <= tort_state;
          transient  <= cnt_value;
        end
      end
      grn_pkg::st_measure: begin
        if (returned) begin
          period <= cnt_value;
        end
      end
      grn_pkg::st_emit: begin
        if (!res_full && cur_state < last_state) begin
          cur_state <= cur_state + 1'b1;
        end
      end
      default: ;
    endcase
  end

  // a job range must not be reversed.
  a_job_order: assert property (@(posedge clk) disable iff (rst)
    job_re |-> (job_head.first_state <= job_head.last_state))
    else $error("attractor_fsm: job with first_state above last_state");

endmodule

/* logic/step_counter.sv */
module step_counter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clear,
  input  logic                 en,
  output grn_pkg::step_count_t value
);

  always_ff @(posedge clk) begin
    if (rst) begin
      value <= '0;
    end else if (clear) begin
      value <= '0; // clear wins over en.
    end else if (en) begin
      value <= value + 1'b1;
    end
  end

  // an increment must never land back on zero.
  a_no_wrap: assert property (@(posedge clk) disable iff (rst)
    (en && !clear) |=> (value != '0))
    else $error("step_counter: count wrapped, cycle longer than count width");

endmodule

/* logic/net_sim.sv */
module net_sim #(
  parameter int STEPS = 1
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                load,
  input  grn_pkg::net_state_t init,
  input  logic                en,
  output grn_pkg::net_state_t state
);

  grn_pkg::net_state_t stepped;

  // chain of STEPS updates in one cycle.
  always_comb begin
    stepped = state;
    for (int i = 0; i < STEPS; i++) begin
      stepped = grn_pkg::next_state(stepped);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= '0;
    end else if (load) begin
      state <= init;
    end else if (en) begin
      state <= stepped;
    end
  end

  // the controller never loads and steps in the same cycle.
  a_load_en_excl: assert property (@(posedge clk) disable iff (rst) !(load && en))
    else $error("net_sim: load and en high together");

endmodule

/* logic/grn_job_pkg.sv */
package grn_job_pkg;

  localparam int job_depth = 4;
  localparam int result_depth = 8;

  // inclusive range of initial states.
  typedef struct packed {
    grn_pkg::net_state_t first_state;
    grn_pkg::net_state_t last_state;
  } job_t;

  typedef struct packed {
    grn_pkg::net_state_t init_state;
    grn_pkg::net_state_t attractor_state;
    grn_pkg::step_count_t transient; // floyd meeting index.
    grn_pkg::step_count_t period;
  } result_t;

endpackage

/* logic/grn_pkg.sv */
package grn_pkg;

  localparam int n_genes = 12;
  localparam int count_width = 16;

  typedef logic [n_genes-1:0] net_state_t;
  typedef logic [count_width-1:0] step_count_t;

  typedef enum logic [2:0] {
    st_idle,
    st_fetch,
    st_load,
    st_seek,
    st_measure,
    st_emit,
    st_done
  } fsm_state_e;

  // one synchronous update of every gene.
  function automatic net_state_t next_state(input net_state_t cur);
    net_state_t nxt;
    for (int i = 0; i < n_genes; i++) begin
      nxt[i] = cur[(i + 1) % n_genes] ^
               (cur[(i + 3) % n_genes] & ~cur[(i + 7) % n_genes]);
    end
    return nxt;
  endfunction

endpackage
